//--- Bender.yml
package:
  name: ldst_unit

sources:
  - files:
      - hw/rv32i_isa_pkg.sv
      - hw/ldst_bus_pkg.sv
      - hw/imm_decode.sv
      - hw/gpr_file.sv
      - hw/exu_ldst_handler.sv
      - hw/data_ram.sv
      - hw/ldst_unit_top.sv
  - target: test
    files:
      - tb/ldst_unit_assertions.sv
      - tb/ldst_unit_tb.sv

//--- hw/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             req_vld,
    output logic                             req_rdy,
    input  logic [ldst_bus_pkg::ldst_aw-1:0] req_addr,
    input  logic                             req_st,
    input  logic [ldst_bus_pkg::ldst_dw-1:0] req_data,
    input  logic [ldst_bus_pkg::ldst_sw-1:0] req_strb,
    output logic                             rsp_vld,
    input  logic                             rsp_rdy,
    output logic [ldst_bus_pkg::ldst_dw-1:0] rsp_data
);
    import ldst_bus_pkg::*;

    logic [ldst_dw-1:0]        mem [ram_depth];
    logic [ram_depth_log2-1:0] idx;
    logic [ldst_cnt_w-1:0]     cnt;
    logic                      req_hsk;
    logic                      rsp_hsk;

    // word index, upper address bits wrap
    assign idx = req_addr[ram_depth_log2+ldst_bo_w-1:ldst_bo_w];

    assign req_hsk = req_vld & req_rdy;
    assign rsp_hsk = rsp_vld & rsp_rdy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // latency counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cnt holds the cycles left until the response, 0 means idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (req_hsk) begin
            cnt <= ldst_cnt_w'(ldst_rsp_lat);
        end else if (cnt > ldst_cnt_w'(1)) begin
            cnt <= cnt - 1'b1;
        end else if (rsp_hsk) begin
            cnt <= '0;
        end
    end

    // only one request in flight
    assign req_rdy = (cnt == '0);
    assign rsp_vld = (cnt == ldst_cnt_w'(1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (req_hsk) begin
            // old word comes back on stores too
            rsp_data <= mem[idx];
            if (req_st) begin
                for (int b = 0; b < ldst_sw; b++) begin
                    if (req_strb[b]) begin
                        mem[idx][b*8 +: 8] <= req_data[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- hw/exu_ldst_handler.sv
`timescale 1ns/1ps

module exu_ldst_handler (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               sel,
    input  rv32i_isa_pkg::rv32i_inst_t         inst,
    output logic                               req_vld,
    input  logic                               req_rdy,
    output logic [ldst_bus_pkg::ldst_aw-1:0]   req_addr,
    output logic                               req_st,
    output logic [ldst_bus_pkg::ldst_dw-1:0]   req_data,
    output logic [ldst_bus_pkg::ldst_sw-1:0]   req_strb,
    input  logic                               rsp_vld,
    output logic                               rsp_rdy,
    input  logic [ldst_bus_pkg::ldst_dw-1:0]   rsp_data,
    output logic [rv32i_isa_pkg::gpr_aw-1:0]   r1_addr,
    input  logic [rv32i_isa_pkg::xlen-1:0]     r1_data,
    output logic [rv32i_isa_pkg::gpr_aw-1:0]   r2_addr,
    input  logic [rv32i_isa_pkg::xlen-1:0]     r2_data,
    output logic                               w_en,
    output logic [rv32i_isa_pkg::gpr_aw-1:0]   w_addr,
    output logic [rv32i_isa_pkg::xlen-1:0]     w_data,
    output logic                               done
);
    import rv32i_isa_pkg::*;
    import ldst_bus_pkg::*;

    logic                req_hsk;
    logic                rsp_hsk;
    logic                req_pend;
    logic                is_ld_nxt;
    logic                is_st_nxt;
    logic                is_ld;
    logic [funct3_w-1:0] ld_funct3;
    logic [gpr_aw-1:0]   ld_rd;
    logic [xlen-1:0]     i_imm;
    logic [xlen-1:0]     s_imm;
    logic [xlen-1:0]     offset;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshakes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign req_vld = sel & ~req_pend;
    assign rsp_rdy = 1'b1;
    assign req_hsk = req_vld & req_rdy;
    assign rsp_hsk = rsp_vld & rsp_rdy;
    assign done    = rsp_hsk;

    // one request per sel, cleared once the response lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_pend <= 1'b0;
        end else if (req_hsk) begin
            req_pend <= 1'b1;
        end else if (rsp_hsk) begin
            req_pend <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign is_ld_nxt = (inst.base.opcode == opcode_load);
    assign is_st_nxt = (inst.base.opcode == opcode_store);

    imm_decode u_imm_decode (
        .inst  (inst),
        .i_imm (i_imm),
        .s_imm (s_imm)
    );

    assign offset = is_ld_nxt ? i_imm : s_imm;

    always_comb begin
        r1_addr = '0;
        r2_addr = '0;
        if (is_ld_nxt) begin
            r1_addr = inst.i.rs1;
        end else if (is_st_nxt) begin
            r1_addr = inst.s.rs1;
            r2_addr = inst.s.rs2;
        end
    end

    assign req_addr = r1_data + offset;
    assign req_st   = is_st_nxt;
    assign req_data = r2_data;

    always_comb begin
        case (inst.s.funct3)
            store_funct3_sb: req_strb = strb_byte;
            store_funct3_sh: req_strb = strb_half;
            store_funct3_sw: req_strb = strb_word;
            default:         req_strb = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (req_hsk) begin
            is_ld     <= is_ld_nxt;
            ld_funct3 <= inst.i.funct3;
            ld_rd     <= inst.i.rd;
        end
    end

    assign w_en   = sel & is_ld & rsp_hsk;
    assign w_addr = ld_rd;

    always_comb begin
        case (ld_funct3)
            load_funct3_lb:  w_data = {{(xlen-8){rsp_data[7]}}, rsp_data[7:0]};
            load_funct3_lh:  w_data = {{(xlen-16){rsp_data[15]}}, rsp_data[15:0]};
            load_funct3_lw:  w_data = rsp_data;
            load_funct3_lbu: w_data = {{(xlen-8){1'b0}}, rsp_data[7:0]};
            load_funct3_lhu: w_data = {{(xlen-16){1'b0}}, rsp_data[15:0]};
            default:         w_data = 'x;
        endcase
    end

endmodule

//--- hw/gpr_file.sv
`timescale 1ns/1ps

module gpr_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [rv32i_isa_pkg::gpr_aw-1:0] r1_addr,
    output logic [rv32i_isa_pkg::xlen-1:0]   r1_data,
    input  logic [rv32i_isa_pkg::gpr_aw-1:0] r2_addr,
    output logic [rv32i_isa_pkg::xlen-1:0]   r2_data,
    input  logic                             w_en,
    input  logic [rv32i_isa_pkg::gpr_aw-1:0] w_addr,
    input  logic [rv32i_isa_pkg::xlen-1:0]   w_data,
    input  logic                             dbg_wen,
    input  logic [rv32i_isa_pkg::gpr_aw-1:0] dbg_waddr,
    input  logic [rv32i_isa_pkg::xlen-1:0]   dbg_wdata,
    input  logic [rv32i_isa_pkg::gpr_aw-1:0] dbg_raddr,
    output logic [rv32i_isa_pkg::xlen-1:0]   dbg_rdata
);
    import rv32i_isa_pkg::*;

    localparam int gpr_num = 1 << gpr_aw;

    // x0 has no storage
    logic [xlen-1:0] regs [1:gpr_num-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < gpr_num; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (dbg_wen && (dbg_waddr != '0)) begin
                regs[dbg_waddr] <= dbg_wdata;
            end
            // exu write comes last so it wins on the same index
            if (w_en && (w_addr != '0)) begin
                regs[w_addr] <= w_data;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign r1_data   = (r1_addr == '0) ? '0 : regs[r1_addr];
    assign r2_data   = (r2_addr == '0) ? '0 : regs[r2_addr];
    assign dbg_rdata = (dbg_raddr == '0) ? '0 : regs[dbg_raddr];

endmodule

//--- hw/imm_decode.sv
`timescale 1ns/1ps

module imm_decode (
    input  rv32i_isa_pkg::rv32i_inst_t     inst,
    output logic [rv32i_isa_pkg::xlen-1:0] i_imm,
    output logic [rv32i_isa_pkg::xlen-1:0] s_imm
);
    import rv32i_isa_pkg::*;

    logic [imm_w-1:0] i_raw;
    logic [imm_w-1:0] s_raw;

    // i-type keeps the immediate in one piece
    assign i_raw = inst.i.imm;

    // s-type splits it around rs2/rs1/funct3
    assign s_raw = {inst.s.imm_hi, inst.s.imm_lo};

    assign i_imm = {{(xlen-imm_w){i_raw[imm_w-1]}}, i_raw};
    assign s_imm = {{(xlen-imm_w){s_raw[imm_w-1]}}, s_raw};

endmodule

//--- hw/ldst_bus_pkg.sv
package ldst_bus_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request/response bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ldst_aw   = 32;
    localparam int ldst_sw   = 4;
    localparam int ldst_dw   = ldst_sw * 8;
    localparam int ldst_bo_w = $clog2(ldst_sw);

    // data always sits in the low lanes
    localparam logic [ldst_sw-1:0] strb_byte = 4'b0001;
    localparam logic [ldst_sw-1:0] strb_half = 4'b0011;
    localparam logic [ldst_sw-1:0] strb_word = 4'b1111;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data ram
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ram_depth_log2 = 8;
    localparam int ram_depth      = 1 << ram_depth_log2;

    // cycles from request handshake to response, must be at least 1
    localparam int ldst_rsp_lat = 2;
    localparam int ldst_cnt_w   = $clog2(ldst_rsp_lat + 1);

endpackage

//--- hw/ldst_unit_top.sv
`timescale 1ns/1ps

module ldst_unit_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             sel,
    input  rv32i_isa_pkg::rv32i_inst_t       inst,
    output logic                             done,
    output logic                             wb_en,
    output logic [rv32i_isa_pkg::gpr_aw-1:0] wb_addr,
    output logic [rv32i_isa_pkg::xlen-1:0]   wb_data,
    input  logic                             dbg_wen,
    input  logic [rv32i_isa_pkg::gpr_aw-1:0] dbg_waddr,
    input  logic [rv32i_isa_pkg::xlen-1:0]   dbg_wdata,
    input  logic [rv32i_isa_pkg::gpr_aw-1:0] dbg_raddr,
    output logic [rv32i_isa_pkg::xlen-1:0]   dbg_rdata
);
    import rv32i_isa_pkg::*;
    import ldst_bus_pkg::*;

    logic               req_vld;
    logic               req_rdy;
    logic [ldst_aw-1:0] req_addr;
    logic               req_st;
    logic [ldst_dw-1:0] req_data;
    logic [ldst_sw-1:0] req_strb;
    logic               rsp_vld;
    logic               rsp_rdy;
    logic [ldst_dw-1:0] rsp_data;
    logic [gpr_aw-1:0]  r1_addr;
    logic [xlen-1:0]    r1_data;
    logic [gpr_aw-1:0]  r2_addr;
    logic [xlen-1:0]    r2_data;

    exu_ldst_handler u_exu_ldst_handler (
        .clk      (clk),
        .rst_n    (rst_n),
        .sel      (sel),
        .inst     (inst),
        .req_vld  (req_vld),
        .req_rdy  (req_rdy),
        .req_addr (req_addr),
        .req_st   (req_st),
        .req_data (req_data),
        .req_strb (req_strb),
        .rsp_vld  (rsp_vld),
        .rsp_rdy  (rsp_rdy),
        .rsp_data (rsp_data),
        .r1_addr  (r1_addr),
        .r1_data  (r1_data),
        .r2_addr  (r2_addr),
        .r2_data  (r2_data),
        .w_en     (wb_en),
        .w_addr   (wb_addr),
        .w_data   (wb_data),
        .done     (done)
    );

    // writeback port doubles as the observation port
    gpr_file u_gpr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .r1_addr   (r1_addr),
        .r1_data   (r1_data),
        .r2_addr   (r2_addr),
        .r2_data   (r2_data),
        .w_en      (wb_en),
        .w_addr    (wb_addr),
        .w_data    (wb_data),
        .dbg_wen   (dbg_wen),
        .dbg_waddr (dbg_waddr),
        .dbg_wdata (dbg_wdata),
        .dbg_raddr (dbg_raddr),
        .dbg_rdata (dbg_rdata)
    );

    data_ram u_data_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_vld  (req_vld),
        .req_rdy  (req_rdy),
        .req_addr (req_addr),
        .req_st   (req_st),
        .req_data (req_data),
        .req_strb (req_strb),
        .rsp_vld  (rsp_vld),
        .rsp_rdy  (rsp_rdy),
        .rsp_data (rsp_data)
    );

endmodule

//--- hw/rv32i_isa_pkg.sv
package rv32i_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int xlen     = 32;
    localparam int gpr_aw   = 5;
    localparam int opcode_w = 7;
    localparam int funct3_w = 3;
    localparam int imm_w    = 12;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes and sub-ops
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [opcode_w-1:0] opcode_load  = 7'b0000011;
    localparam logic [opcode_w-1:0] opcode_store = 7'b0100011;

    localparam logic [funct3_w-1:0] load_funct3_lb  = 3'b000;
    localparam logic [funct3_w-1:0] load_funct3_lh  = 3'b001;
    localparam logic [funct3_w-1:0] load_funct3_lw  = 3'b010;
    localparam logic [funct3_w-1:0] load_funct3_lbu = 3'b100;
    localparam logic [funct3_w-1:0] load_funct3_lhu = 3'b101;

    localparam logic [funct3_w-1:0] store_funct3_sb = 3'b000;
    localparam logic [funct3_w-1:0] store_funct3_sh = 3'b001;
    localparam logic [funct3_w-1:0] store_funct3_sw = 3'b010;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [xlen-opcode_w-1:0] payload;
        logic [opcode_w-1:0]      opcode;
    } rv32i_base_t;

    typedef struct packed {
        logic [imm_w-1:0]    imm;
        logic [gpr_aw-1:0]   rs1;
        logic [funct3_w-1:0] funct3;
        logic [gpr_aw-1:0]   rd;
        logic [opcode_w-1:0] opcode;
    } rv32i_i_t;

    // imm split around rs2/rs1/funct3, see imm_decode
    typedef struct packed {
        logic [imm_w-6:0]    imm_hi;
        logic [gpr_aw-1:0]   rs2;
        logic [gpr_aw-1:0]   rs1;
        logic [funct3_w-1:0] funct3;
        logic [4:0]          imm_lo;
        logic [opcode_w-1:0] opcode;
    } rv32i_s_t;

    typedef union packed {
        rv32i_base_t base;
        rv32i_i_t    i;
        rv32i_s_t    s;
    } rv32i_inst_t;

endpackage

//--- src.f
hw/rv32i_isa_pkg.sv
hw/ldst_bus_pkg.sv
hw/imm_decode.sv
hw/gpr_file.sv
hw/exu_ldst_handler.sv
hw/data_ram.sv
hw/ldst_unit_top.sv
tb/ldst_unit_assertions.sv
tb/ldst_unit_tb.sv

//--- tb/ldst_unit_assertions.sv
`timescale 1ns/1ps

module ldst_unit_assertions (
    input logic clk,
    input logic rst_n,
    input logic req_vld,
    input logic req_rdy,
    input logic req_st,
    input logic rsp_vld,
    input logic rsp_rdy,
    input logic req_pend,
    input logic w_en,
    input logic done
);
    import ldst_bus_pkg::*;

    // failed property count
    int fail_cnt = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    no_req_while_pend: assert property (@(posedge clk) disable iff (!rst_n)
        (req_vld && req_rdy) |=> (!req_vld) [* ldst_rsp_lat])
    else begin
        $error("req_vld high while a request is pending");
        fail_cnt++;
    end

    // response lands exactly ldst_rsp_lat cycles after the request
    rsp_after_lat: assert property (@(posedge clk) disable iff (!rst_n)
        (req_vld && req_rdy) |=> (!rsp_vld) [* ldst_rsp_lat - 1] ##1 rsp_vld)
    else begin
        $error("rsp_vld not seen %0d cycles after the request", ldst_rsp_lat);
        fail_cnt++;
    end

    done_is_rsp_hsk: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (req_pend && !req_rdy))
    else begin
        $error("done raised outside a pending response");
        fail_cnt++;
    end

    wen_only_on_load: assert property (@(posedge clk) disable iff (!rst_n)
        w_en |-> $past(req_vld && req_rdy && !req_st, ldst_rsp_lat))
    else begin
        $error("w_en raised outside a load response");
        fail_cnt++;
    end

    no_done_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !done)
    else begin
        $error("done high right after reset");
        fail_cnt++;
    end

endmodule

//--- tb/ldst_unit_tb.sv
`timescale 1ns/1ps

module ldst_unit_tb;
    import rv32i_isa_pkg::*;
    import ldst_bus_pkg::*;

    localparam int op_timeout = 20;

    logic              clk;
    logic              rst_n;
    logic              sel;
    rv32i_inst_t       inst;
    logic              done;
    logic              wb_en;
    logic [gpr_aw-1:0] wb_addr;
    logic [xlen-1:0]   wb_data;
    logic              dbg_wen;
    logic [gpr_aw-1:0] dbg_waddr;
    logic [xlen-1:0]   dbg_wdata;
    logic [gpr_aw-1:0] dbg_raddr;
    logic [xlen-1:0]   dbg_rdata;

    // reference model
    logic [xlen-1:0]     model_regs [32];
    logic [xlen-1:0]     model_mem [ram_depth];
    logic [funct3_w-1:0] ld_ops [5];
    logic [funct3_w-1:0] st_ops [3];
    integer              seed;
    int                  errors;
    int                  checks;
    int                  obs_lat;
    logic                obs_wb;
    logic                obs_wb_early;
    logic [gpr_aw-1:0]   obs_wb_addr;
    logic [xlen-1:0]     obs_wb_data;

    ldst_unit_top ldst_unit_top_i (.*);

    bind exu_ldst_handler ldst_unit_assertions u_ldst_unit_assertions (.*);

    always #4 clk = ~clk;

    function automatic int pick(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // base register is one of x0..x4, all holding aligned in-range addresses
    function automatic logic [xlen-1:0] mk_op(input logic st, input logic [2:0] f3,
                                              input int r, input int word);
        int          base;
        logic [11:0] imm;
        base = pick(0, 4);
        imm  = 12'(word * 4 - int'(model_regs[base]));
        if (st) begin
            return {imm[11:5], 5'(r), 5'(base), f3, imm[4:0], opcode_store};
        end else begin
            return {imm, 5'(base), f3, 5'(r), opcode_load};
        end
    endfunction

    task automatic model_apply(input logic [xlen-1:0] w, output logic [xlen-1:0] res);
        logic [xlen-1:0] addr;
        logic [xlen-1:0] word;
        logic [7:0]      idx;
        if (w[6:0] == opcode_load) begin
            addr = model_regs[w[19:15]] + {{20{w[31]}}, w[31:20]};
            word = model_mem[addr[9:2]];
            case (w[14:12])
                load_funct3_lb:  res = {{24{word[7]}}, word[7:0]};
                load_funct3_lh:  res = {{16{word[15]}}, word[15:0]};
                load_funct3_lbu: res = {24'b0, word[7:0]};
                load_funct3_lhu: res = {16'b0, word[15:0]};
                default:         res = word;
            endcase
            if (w[11:7] != 5'd0) begin
                model_regs[w[11:7]] = res;
            end
        end else begin
            addr = model_regs[w[19:15]] + {{20{w[31]}}, w[31:25], w[11:7]};
            idx  = addr[9:2];
            res  = model_regs[w[24:20]];
            // low lanes only
            case (w[14:12])
                store_funct3_sb: model_mem[idx][7:0] = res[7:0];
                store_funct3_sh: model_mem[idx][15:0] = res[15:0];
                default:         model_mem[idx] = res;
            endcase
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string why);
        $display("timeout: %s at %0t", why, $time);
        $display("sim failed");
        $finish;
    endtask

    task automatic mismatch(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic set_reg(input int r, input logic [xlen-1:0] v);
        @(posedge clk);
        dbg_wen   <= 1'b1;
        dbg_waddr <= 5'(r);
        dbg_wdata <= v;
        @(posedge clk);
        dbg_wen <= 1'b0;
        model_regs[r] = v;
    endtask

    task automatic check_reg(input int r);
        @(posedge clk);
        dbg_raddr <= 5'(r);
        @(negedge clk);
        checks++;
        if (dbg_rdata !== model_regs[r]) begin
            mismatch($sformatf("dbg_rdata x%0d", r), dbg_rdata, model_regs[r]);
        end
    endtask

    task automatic run_op(input logic [xlen-1:0] w);
        int   cycles;
        logic got;
        cycles       = 0;
        got          = 1'b0;
        obs_wb       = 1'b0;
        obs_wb_early = 1'b0;
        @(posedge clk);
        sel  <= 1'b1;
        inst <= w;
        while (!got && cycles < op_timeout) begin
            @(negedge clk);
            if (done) begin
                got         = 1'b1;
                obs_wb      = wb_en;
                obs_wb_addr = wb_addr;
                obs_wb_data = wb_data;
            end else begin
                obs_wb_early = obs_wb_early | wb_en;
                cycles++;
            end
        end
        if (!got) begin
            abort_run("done did not follow sel within 20 cycles");
        end else begin
            obs_lat = cycles;
            @(posedge clk);
            sel <= 1'b0;
        end
    endtask

    task automatic exec_checked(input logic [xlen-1:0] w);
        logic [xlen-1:0] exp;
        logic            is_load;
        is_load = (w[6:0] == opcode_load);
        model_apply(w, exp);
        run_op(w);
        checks += 3;
        if (obs_lat != ldst_rsp_lat) begin
            mismatch("done latency", obs_lat, ldst_rsp_lat);
        end
        if (obs_wb_early) begin
            mismatch("wb_en before done", 1, 0);
        end
        if (obs_wb !== is_load) begin
            mismatch("wb_en", obs_wb, is_load);
        end
        if (is_load) begin
            checks += 2;
            if (obs_wb_addr !== w[11:7]) begin
                mismatch("wb_addr", obs_wb_addr, w[11:7]);
            end
            if (obs_wb_data !== exp) begin
                mismatch("wb_data", obs_wb_data, exp);
            end
            check_reg(w[11:7]);
        end
    endtask

    task automatic end_test(input string name, input int mark);
        $display("test %s: %0d errors", name, errors - mark);
    endtask

    initial begin
        int              mark;
        int              word;
        int              r;
        int              f;
        logic [xlen-1:0] val;
        logic [xlen-1:0] w;
        clk       = 1'b0;
        rst_n     = 1'b0;
        sel       = 1'b0;
        inst      = '0;
        dbg_wen   = 1'b0;
        dbg_waddr = '0;
        dbg_wdata = '0;
        dbg_raddr = '0;
        seed      = 32'h513523bb;
        errors    = 0;
        checks    = 0;
        ld_ops    = '{load_funct3_lb, load_funct3_lh, load_funct3_lbu, load_funct3_lhu,
                      load_funct3_lw};
        st_ops    = '{store_funct3_sb, store_funct3_sh, store_funct3_sw};
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (done !== 1'b0 || wb_en !== 1'b0) begin
            $display("done or wb_en is high right after reset at %0t", $time);
            errors++;
        end

        // x1..x4 are bases, never load targets
        for (r = 1; r < 32; r++) begin
            val = $random(seed);
            set_reg(r, (r < 5) ? (val & 32'h3fc) : val);
        end
        for (word = 0; word < ram_depth; word++) begin
            set_reg(5, $random(seed));
            w = mk_op(1'b1, store_funct3_sw, 5, word);
            model_apply(w, val);
            run_op(w);
        end

        mark = errors;
        repeat (16) begin
            word = pick(0, ram_depth - 1);
            exec_checked(mk_op(1'b1, store_funct3_sw, pick(5, 31), word));
            exec_checked(mk_op(1'b0, load_funct3_lw, pick(5, 31), word));
        end
        end_test("word round trip", mark);

        mark = errors;
        repeat (16) begin
            word = pick(0, ram_depth - 1);
            f    = pick(0, 1);
            exec_checked(mk_op(1'b1, st_ops[f], pick(5, 31), word));
            exec_checked(mk_op(1'b0, load_funct3_lw, pick(5, 31), word));
        end
        end_test("byte and half stores", mark);

        // sign bits 7 and 15 walk through all four combinations per load type
        mark = errors;
        for (r = 0; r < 16; r++) begin
            word    = pick(0, ram_depth - 1);
            val     = $random(seed);
            val[7]  = r[0];
            val[15] = r[1];
            set_reg(5, val);
            exec_checked(mk_op(1'b1, store_funct3_sw, 5, word));
            exec_checked(mk_op(1'b0, ld_ops[r[3:2]], pick(5, 31), word));
        end
        end_test("load extension", mark);

        mark = errors;
        repeat (4) begin
            word = pick(0, ram_depth - 1);
            f    = pick(0, 4);
            exec_checked(mk_op(1'b0, ld_ops[f], 0, word));
        end
        end_test("x0 destination", mark);

        mark = errors;
        for (r = 0; r < 8; r++) begin
            word = pick(0, ram_depth - 1);
            exec_checked(mk_op(1'b1, st_ops[r % 3], 5 + r, word));
            exec_checked(mk_op(1'b0, ld_ops[r % 5], 5 + r, word));
        end
        end_test("timing", mark);

        mark = errors;
        repeat (200) begin
            word = pick(0, ram_depth - 1);
            r    = pick(4, 31);
            if (pick(0, 1) == 1) begin
                f = pick(0, 2);
                exec_checked(mk_op(1'b1, st_ops[f], r, word));
            end else begin
                f = pick(0, 4);
                // index 4 stands in for x0 as destination
                exec_checked(mk_op(1'b0, ld_ops[f], (r == 4) ? 0 : r, word));
            end
        end
        end_test("random mix", mark);

        errors += ldst_unit_top_i.u_exu_ldst_handler.u_ldst_unit_assertions.fail_cnt;
        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
